// File: design/tile_pkg.sv
// Compute tile package with the address map, memory sizes, boot ROM tag and shared types
package tile_pkg;

   // Bus widths
   typedef logic [31:0] addr_t;                   // Byte address
   typedef logic [31:0] data_t;                   // Data word
   typedef logic [3:0]  sel_t;                    // One select bit per byte

   // Address map fields
   typedef logic [3:0]  region_t;                 // Top address nibble
   typedef logic [7:0]  lmem_idx_t;               // Local memory word index
   typedef logic [3:0]  rom_idx_t;                // Boot ROM word index

   // Bus port FSM
   typedef enum logic [1:0] {
      IDLE  = 2'd0,                               // Waiting for req_i
      ISSUE = 2'd1,                               // Command pulse to decoder
      WAIT  = 2'd2,                               // Waiting for the response
      ACK   = 2'd3                                // Holding ack_o until req_i falls
   } port_state_t;

   // Region values of the top nibble
   localparam region_t REGION_DM   = 4'h0;        // Local data memory
   localparam region_t REGION_BOOT = 4'hF;        // Boot ROM

   // Word index starts above the byte offset
   localparam int ADDR_WORD_LSB = 2;

   // Memory sizes in words
   localparam int LMEM_WORDS = 256;
   localparam int ROM_WORDS  = 16;

   // ROM contents: tag in the upper bytes, word index in the low byte
   localparam data_t BOOT_TAG = 32'hB007_0000;

endpackage

// File: design/local_sram.sv
// Local data memory, single port, word addressed, with byte-select writes
`timescale 1ns/1ps

module local_sram
   import tile_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   input  logic       cs_i,
   input  logic       we_i,
   input  lmem_idx_t  idx_i,
   input  data_t      wdata_i,
   input  sel_t       sel_i,
   output logic       done_o,
   output data_t      rdata_o
);

   data_t mem [LMEM_WORDS];

   // Done strobe for reads and writes alike
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         done_o <= 1'b0;
      end else begin
         done_o <= cs_i;
      end
   end

   // Byte lane writes
   always_ff @(posedge clk) begin
      if (cs_i && we_i) begin
         for (int b = 0; b < $bits(sel_t); b++) begin
            if (sel_i[b]) mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

   // Registered read
   always_ff @(posedge clk) begin
      if (cs_i && !we_i) begin
         rdata_o <= mem[idx_i];
      end
   end

endmodule

// File: design/boot_rom.sv
// Boot ROM whose words hold the boot tag with the word index in the low byte
`timescale 1ns/1ps

module boot_rom
   import tile_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      cs_i,
   input  rom_idx_t  idx_i,
   output logic      done_o,
   output data_t     rdata_o
);

   data_t rom_table [ROM_WORDS];

   // Constant table
   for (genvar i = 0; i < ROM_WORDS; i++) begin : gen_rom_word
      assign rom_table[i] = {BOOT_TAG[31:8], 8'(i)};
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         done_o <= 1'b0;
      end else begin
         done_o <= cs_i;                         // One cycle after select
      end
   end

   always_ff @(posedge clk) begin
      if (cs_i) begin
         rdata_o <= rom_table[idx_i];
      end
   end

endmodule

// File: design/bus_master_port.sv
// Bus master port taking four-phase req/ack transfers and passing them inward as commands
`timescale 1ns/1ps

module bus_master_port
   import tile_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n_i,

   // Four-phase side
   input  logic   req_i,
   input  addr_t  addr_i,
   input  logic   we_i,
   input  data_t  wdata_i,
   input  sel_t   sel_i,
   output logic   ack_o,
   output data_t  rdata_o,
   output logic   err_o,

   // Command to decoder
   output logic   cmd_valid_o,
   output addr_t  cmd_addr_o,
   output logic   cmd_we_o,
   output data_t  cmd_wdata_o,
   output sel_t   cmd_sel_o,

   // Response from decoder
   input  logic   rsp_valid_i,
   input  data_t  rsp_rdata_i,
   input  logic   rsp_err_i
);

   port_state_t state_q;

   assign cmd_valid_o = (state_q == ISSUE);      // Single cycle, state lasts one clock
   assign ack_o       = (state_q == ACK);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         rdata_o <= '0;
         err_o   <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (req_i) state_q <= ISSUE;
            end
            ISSUE: begin
               state_q <= WAIT;
            end
            WAIT: begin
               if (rsp_valid_i) begin
                  rdata_o <= rsp_rdata_i;        // Held while ack_o is high
                  err_o   <= rsp_err_i;
                  state_q <= ACK;
               end
            end
            ACK: begin
               if (!req_i) state_q <= IDLE;      // Fourth phase
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Request fields, captured once per transfer
   always_ff @(posedge clk) begin
      if (state_q == IDLE && req_i) begin
         cmd_addr_o  <= addr_i;
         cmd_we_o    <= we_i;
         cmd_wdata_o <= wdata_i;
         cmd_sel_o   <= sel_i;
      end
   end

endmodule

// File: design/addr_decoder.sv
// Address decoder that strobes local memory or boot ROM and returns data or error responses
`timescale 1ns/1ps

module addr_decoder
   import tile_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,

   // Command from port
   input  logic       cmd_valid_i,
   input  addr_t      cmd_addr_i,
   input  logic       cmd_we_i,
   input  data_t      cmd_wdata_i,
   input  sel_t       cmd_sel_i,

   // Response to port
   output logic       rsp_valid_o,
   output data_t      rsp_rdata_o,
   output logic       rsp_err_o,

   // Local SRAM
   output logic       sram_cs_o,
   output logic       sram_we_o,
   output lmem_idx_t  sram_idx_o,
   output data_t      sram_wdata_o,
   output sel_t       sram_sel_o,
   input  logic       sram_done_i,
   input  data_t      sram_rdata_i,

   // Boot ROM
   output logic       rom_cs_o,
   output rom_idx_t   rom_idx_o,
   input  logic       rom_done_i,
   input  data_t      rom_rdata_i
);

   region_t region;
   logic    hit_dm;
   logic    hit_boot;
   logic    err_q;

   assign region   = cmd_addr_i[$bits(addr_t)-1 -: $bits(region_t)];
   assign hit_dm   = (region == REGION_DM);
   assign hit_boot = (region == REGION_BOOT) && !cmd_we_i;     // ROM takes reads only

   // Memory strobes in the command cycle
   assign sram_cs_o    = cmd_valid_i && hit_dm;
   assign sram_we_o    = cmd_we_i;
   assign sram_idx_o   = cmd_addr_i[ADDR_WORD_LSB +: $bits(lmem_idx_t)];
   assign sram_wdata_o = cmd_wdata_i;
   assign sram_sel_o   = cmd_sel_i;

   assign rom_cs_o     = cmd_valid_i && hit_boot;
   assign rom_idx_o    = cmd_addr_i[ADDR_WORD_LSB +: $bits(rom_idx_t)];

   // Unmapped regions and ROM writes
   // The error waits in err_q for the cycle a memory would take,
   // so every response leaves the decoder two cycles after the command
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q       <= 1'b0;
         rsp_valid_o <= 1'b0;
         rsp_err_o   <= 1'b0;
      end else begin
         err_q       <= cmd_valid_i && !hit_dm && !hit_boot;
         rsp_valid_o <= sram_done_i || rom_done_i || err_q;
         rsp_err_o   <= err_q;
      end
   end

   // Reply data mux
   always_ff @(posedge clk) begin
      if (sram_done_i) begin
         rsp_rdata_o <= sram_rdata_i;
      end else if (rom_done_i) begin
         rsp_rdata_o <= rom_rdata_i;
      end else if (err_q) begin
         rsp_rdata_o <= '0;                      // No data on errors
      end
   end

endmodule

// File: design/compute_tile_dm.sv
// Compute tile memory side: four-phase bus port, address decoder, local SRAM and boot ROM
`timescale 1ns/1ps

module compute_tile_dm
   import tile_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n_i,
   input  logic   req_i,
   input  addr_t  addr_i,
   input  logic   we_i,
   input  data_t  wdata_i,
   input  sel_t   sel_i,
   output logic   ack_o,
   output data_t  rdata_o,
   output logic   err_o
);

   // Port to decoder
   logic       cmd_valid;
   addr_t      cmd_addr;
   logic       cmd_we;
   data_t      cmd_wdata;
   sel_t       cmd_sel;
   logic       rsp_valid;
   data_t      rsp_rdata;
   logic       rsp_err;

   // Decoder to memories
   logic       sram_cs;
   logic       sram_we;
   lmem_idx_t  sram_idx;
   data_t      sram_wdata;
   sel_t       sram_sel;
   logic       sram_done;
   data_t      sram_rdata;
   logic       rom_cs;
   rom_idx_t   rom_idx;
   logic       rom_done;
   data_t      rom_rdata;

   bus_master_port u_port (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .req_i       (req_i),
      .addr_i      (addr_i),
      .we_i        (we_i),
      .wdata_i     (wdata_i),
      .sel_i       (sel_i),
      .ack_o       (ack_o),
      .rdata_o     (rdata_o),
      .err_o       (err_o),
      .cmd_valid_o (cmd_valid),
      .cmd_addr_o  (cmd_addr),
      .cmd_we_o    (cmd_we),
      .cmd_wdata_o (cmd_wdata),
      .cmd_sel_o   (cmd_sel),
      .rsp_valid_i (rsp_valid),
      .rsp_rdata_i (rsp_rdata),
      .rsp_err_i   (rsp_err)
   );

   addr_decoder u_decoder (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (cmd_valid),
      .cmd_addr_i   (cmd_addr),
      .cmd_we_i     (cmd_we),
      .cmd_wdata_i  (cmd_wdata),
      .cmd_sel_i    (cmd_sel),
      .rsp_valid_o  (rsp_valid),
      .rsp_rdata_o  (rsp_rdata),
      .rsp_err_o    (rsp_err),
      .sram_cs_o    (sram_cs),
      .sram_we_o    (sram_we),
      .sram_idx_o   (sram_idx),
      .sram_wdata_o (sram_wdata),
      .sram_sel_o   (sram_sel),
      .sram_done_i  (sram_done),
      .sram_rdata_i (sram_rdata),
      .rom_cs_o     (rom_cs),
      .rom_idx_o    (rom_idx),
      .rom_done_i   (rom_done),
      .rom_rdata_i  (rom_rdata)
   );

   local_sram u_sram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .cs_i    (sram_cs),
      .we_i    (sram_we),
      .idx_i   (sram_idx),
      .wdata_i (sram_wdata),
      .sel_i   (sram_sel),
      .done_o  (sram_done),
      .rdata_o (sram_rdata)
   );

   boot_rom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .cs_i    (rom_cs),
      .idx_i   (rom_idx),
      .done_o  (rom_done),
      .rdata_o (rom_rdata)
   );

endmodule

// File: bench/tb_compute_tile.sv
// Testbench for the compute tile memory side, four-phase transfers against a reference model
`timescale 1ns/1ps

module tb_compute_tile
   import tile_pkg::*;
();

   localparam int ACK_TIMEOUT      = 50;          // Cycles per handshake wait
   localparam int RANDOM_TRANSFERS = 200;
   localparam logic [31:0] SEED    = 32'd98055;

   logic   clk = 1'b0;
   logic   rst_n_i;
   logic   req_i;
   addr_t  addr_i;
   logic   we_i;
   data_t  wdata_i;
   sel_t   sel_i;
   logic   ack_o;
   data_t  rdata_o;
   logic   err_o;

   data_t        shadow [LMEM_WORDS];             // Expected local memory contents
   logic [31:0]  rng_state = SEED;
   logic         exp_err;
   data_t        exp_rdata;
   logic         chk_rdata;                       // Data compared on good reads only
   logic         ack_prev = 1'b0;
   logic         req_prev = 1'b0;
   int           errors   = 0;
   int           n_checks = 0;
   int           n_tests  = 0;

   compute_tile_dm uut (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (req_i),
      .addr_i  (addr_i),
      .we_i    (we_i),
      .wdata_i (wdata_i),
      .sel_i   (sel_i),
      .ack_o   (ack_o),
      .rdata_o (rdata_o),
      .err_o   (err_o)
   );

   always #10 clk = ~clk;                         // 20 ns period

   function automatic logic [31:0] next_random();
      logic [31:0] s;
      s = rng_state;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      rng_state = s;
      return s;
   endfunction

   // Fill value built from every bit of the word index
   function automatic data_t fill_word(input int idx);
      return {8'(idx), 8'(~idx), 8'(idx ^ 8'h5A), 8'(idx * 7 + 3)};
   endfunction

   // Expected {err, rdata} from the address map rules
   function automatic logic [32:0] expect_response(input addr_t a, input logic we);
      logic [3:0] region;
      region = a[31:28];
      if (region == 4'h0) begin
         return {1'b0, shadow[a[9:2]]};
      end else if (region == 4'hF && !we) begin
         return {1'b0, (BOOT_TAG & 32'hFFFF_FF00) | {28'h0, a[5:2]}};
      end
      return {1'b1, 32'h0};                       // Unmapped or ROM write
   endfunction

   function automatic void update_shadow(input addr_t a, input logic we, input data_t wd,
                                         input sel_t sel);
      if (we && a[31:28] == 4'h0) begin
         for (int b = 0; b < 4; b++) begin
            if (sel[b]) shadow[a[9:2]][8*b +: 8] = wd[8*b +: 8];
         end
      end
   endfunction

   task automatic wait_drive_point();
      @(posedge clk);
      #2;
   endtask

   task automatic end_run();
      $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   endtask

   task automatic close_test(input string name, input int start_errors);
      n_tests++;
      if (errors == start_errors) begin
         $display("Test %0d %s: ok", n_tests, name);
      end else begin
         $display("Test %0d %s: %0d error(s)", n_tests, name, errors - start_errors);
      end
   endtask

   // One four-phase transfer, called at a drive point
   task automatic run_transfer(input addr_t a, input logic we, input data_t wd, input sel_t sel,
                               input int hold, output int latency);
      logic [32:0] exp;
      int          edges;
      exp       = expect_response(a, we);
      exp_err   = exp[32];
      exp_rdata = exp[31:0];
      chk_rdata = !we && !exp[32];
      addr_i    = a;
      we_i      = we;
      wdata_i   = wd;
      sel_i     = sel;
      req_i     = 1'b1;
      latency   = 0;
      edges     = 0;
      do begin
         wait_drive_point();
         edges++;
      end while (!ack_o && edges < ACK_TIMEOUT);
      if (!ack_o) begin
         $display("Timeout at %0t: ack_o did not rise for address %08h", $time, a);
         errors++;
         end_run();
      end else begin
         latency = edges;
         repeat (hold) wait_drive_point();        // Master keeps req_i past ack_o
         req_i = 1'b0;
         edges = 0;
         do begin
            wait_drive_point();
            edges++;
         end while (ack_o && edges < ACK_TIMEOUT);
         if (ack_o) begin
            $display("Timeout at %0t: ack_o did not fall after req_i dropped", $time);
            errors++;
            end_run();
         end else begin
            update_shadow(a, we, wd, sel);
         end
      end
   endtask

   // Response checker, sampling at the falling edge
   always @(negedge clk) begin
      if (rst_n_i && ack_o && !ack_prev) begin
         n_checks++;
         assert (err_o === exp_err) else begin
            errors++;
            $display("CHECK FAILED at %0t: err_o expected %0b, got %0b", $time, exp_err, err_o);
         end
         if (chk_rdata) begin
            n_checks++;
            assert (rdata_o === exp_rdata) else begin
               errors++;
               $display("CHECK FAILED at %0t: rdata_o expected %08h, got %08h",
                        $time, exp_rdata, rdata_o);
            end
         end
      end
      // req_i still high at the last sample keeps the port in ACK
      if (rst_n_i && ack_prev && req_prev) begin
         n_checks++;
         assert (ack_o === 1'b1) else begin
            errors++;
            $display("CHECK FAILED at %0t: ack_o expected 1, got %0b", $time, ack_o);
         end
      end
      ack_prev = ack_o;
      req_prev = req_i;
   end

   initial begin
      addr_t    a;
      logic [31:0] r;
      logic [31:0] r_addr;
      logic [3:0]  region;
      int       lat;
      int       start;
      int       held;
      rst_n_i = 1'b0;
      req_i   = 1'b0;
      addr_i  = '0;
      we_i    = 1'b0;
      wdata_i = '0;
      sel_i   = '0;
      repeat (3) @(posedge clk);
      #2 rst_n_i = 1'b1;
      wait_drive_point();

      // Reset values and first transfer latency
      start = errors;
      n_checks += 3;
      assert (ack_o === 1'b0) else begin
         errors++;
         $display("CHECK FAILED at %0t: ack_o expected 0, got %0b", $time, ack_o);
      end
      assert (err_o === 1'b0) else begin
         errors++;
         $display("CHECK FAILED at %0t: err_o expected 0, got %0b", $time, err_o);
      end
      assert (rdata_o === 32'h0) else begin
         errors++;
         $display("CHECK FAILED at %0t: rdata_o expected 00000000, got %08h", $time, rdata_o);
      end
      run_transfer(32'h0000_0010, 1'b1, 32'hCAFE_0001, 4'hF, 0, lat);
      n_checks++;
      assert (lat == 4) else begin
         errors++;
         $display("CHECK FAILED at %0t: ack_o latency expected 4, got %0d", $time, lat);
      end
      close_test("reset and first ack latency", start);

      for (int i = 0; i < LMEM_WORDS; i++) begin
         run_transfer(addr_t'(i * 4), 1'b1, fill_word(i), 4'hF, 0, lat);
      end

      start = errors;
      run_transfer(32'h0000_0000, 1'b1, 32'h1357_9BDF, 4'hF, 0, lat);
      run_transfer(32'h0000_0000, 1'b0, 32'h0, 4'h0, 0, lat);
      run_transfer(32'h0000_03FC, 1'b1, 32'hDEAD_BEEF, 4'hF, 2, lat);
      run_transfer(32'h0000_03FC, 1'b0, 32'h0, 4'h0, 0, lat);
      run_transfer(32'h0000_0123, 1'b1, 32'h0F0F_A5A5, 4'hF, 0, lat);   // Low bits ignored
      run_transfer(32'h0000_0120, 1'b0, 32'h0, 4'h0, 1, lat);
      close_test("full word write and read", start);

      start = errors;
      run_transfer(32'h0000_0014, 1'b1, 32'h1122_3344, 4'hF, 0, lat);
      run_transfer(32'h0000_0014, 1'b1, 32'hAABB_CCDD, 4'b0101, 0, lat);
      run_transfer(32'h0000_0014, 1'b0, 32'h0, 4'h0, 0, lat);
      run_transfer(32'h0000_0014, 1'b1, 32'h99EE_7766, 4'b1000, 0, lat);
      run_transfer(32'h0000_0014, 1'b1, 32'h5555_0155, 4'b0010, 0, lat);
      run_transfer(32'h0000_0014, 1'b1, 32'hFFFF_FFFF, 4'b0000, 0, lat);
      run_transfer(32'h0000_0014, 1'b0, 32'h0, 4'h0, 0, lat);
      close_test("partial byte selects", start);

      start = errors;
      for (int i = 0; i < ROM_WORDS; i++) begin
         run_transfer(32'hF000_0000 + addr_t'(i * 4), 1'b0, 32'h0, 4'h0, 0, lat);
      end
      run_transfer(32'hF000_0008, 1'b1, 32'h0BAD_0BAD, 4'hF, 0, lat);
      for (int i = 0; i < ROM_WORDS; i++) begin
         run_transfer(32'hF000_0000 + addr_t'(i * 4), 1'b0, 32'h0, 4'h0, 0, lat);
      end
      close_test("boot ROM reads and write error", start);

      start = errors;
      for (int i = 1; i < 15; i++) begin
         run_transfer({4'(i), 28'h000_0040}, 1'b0, 32'h0, 4'h0, 0, lat);
         run_transfer({4'(i), 28'h000_0044}, 1'b1, 32'h1234_5678, 4'hF, 0, lat);
      end
      close_test("unmapped regions", start);

      start = errors;
      held  = 0;
      for (int n = 0; n < RANDOM_TRANSFERS; n++) begin
         r = next_random();
         case (r[1:0])
            2'd0:    region = 4'h0;
            2'd1:    region = 4'hF;
            default: region = r[7:4];             // Any region, mapped or not
         endcase
         r_addr = next_random();
         a      = {region, r_addr[27:0]};
         if (r[13]) held++;
         run_transfer(a, r[8], next_random(), r[12:9], r[13] ? int'(r[15:14]) + 1 : 0, lat);
      end
      $display("Random run held req_i past ack_o on %0d transfers", held);
      close_test("random transfers", start);

      end_run();
   end

endmodule

// File: vlog.f
design/tile_pkg.sv
design/local_sram.sv
design/boot_rom.sv
design/bus_master_port.sv
design/addr_decoder.sv
design/compute_tile_dm.sv
bench/tb_compute_tile.sv

// File: Bender.yml
package:
  name: compute_tile_dm

sources:
  - design/tile_pkg.sv
  - design/local_sram.sv
  - design/boot_rom.sv
  - design/bus_master_port.sv
  - design/addr_decoder.sv
  - design/compute_tile_dm.sv
  - target: simulation
    files:
      - bench/tb_compute_tile.sv
